// ==== source/xbar_pkg.sv ====
// Crossbar shared definitions
`default_nettype none

package xbar_pkg;

  // Port counts and widths
  localparam int unsigned NUM_INIT   = 2;
  localparam int unsigned NUM_TGT    = 2;
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned INIT_ID_W  = 2;
  localparam int unsigned INIT_IDX_W = $clog2(NUM_INIT);        // Initiator index in target IDs
  localparam int unsigned TGT_ID_W   = INIT_ID_W + INIT_IDX_W;
  localparam int unsigned TGT_IDX_W  = $clog2(NUM_TGT + 1);     // Targets plus error responder
  localparam int unsigned MAX_TRANS  = 4;                       // Outstanding per initiator

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [INIT_ID_W-1:0] init_id_t;
  typedef logic [TGT_ID_W-1:0]  tgt_id_t;
  typedef logic [TGT_IDX_W-1:0] route_t;  // 0 and 1 are targets, 2 is the error responder

  // Fixed address map
  localparam addr_t TGT0_BASE = 16'h0000;
  localparam addr_t TGT0_END  = 16'h0FFF;
  localparam addr_t TGT1_BASE = 16'h1000;
  localparam addr_t TGT1_END  = 16'h1FFF;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    addr_t    addr;
    logic     we;
    data_t    wdata;
    init_id_t id;
  } init_req_t;

  typedef struct packed {
    data_t    rdata;
    resp_e    resp;
    init_id_t id;
  } init_rsp_t;

  // Target side carries the extended ID
  typedef struct packed {
    addr_t   addr;
    logic    we;
    data_t   wdata;
    tgt_id_t id;
  } tgt_req_t;

  typedef struct packed {
    data_t   rdata;
    resp_e   resp;
    tgt_id_t id;
  } tgt_rsp_t;

endpackage

`default_nettype wire

// ==== source/xbar_addr_decode.sv ====
// Crossbar address decoder
`timescale 1ns/1ps
`default_nettype none

module xbar_addr_decode (
  input  xbar_pkg::addr_t  addr_i,
  output xbar_pkg::route_t route_o
);

  import xbar_pkg::*;

  logic hit_tgt0;
  logic hit_tgt1;

  assign hit_tgt0 = (addr_i >= TGT0_BASE) && (addr_i <= TGT0_END);
  assign hit_tgt1 = (addr_i >= TGT1_BASE) && (addr_i <= TGT1_END);

  always_comb begin
    if (hit_tgt0) begin
      route_o = route_t'(0);
    end else if (hit_tgt1) begin
      route_o = route_t'(1);
    end else begin
      route_o = route_t'(NUM_TGT);  // Unmapped, send to error responder
    end
  end

endmodule

`default_nettype wire

// ==== source/xbar_err_resp.sv ====
// Decode error responder
`timescale 1ns/1ps
`default_nettype none

module xbar_err_resp (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  xbar_pkg::init_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output xbar_pkg::init_rsp_t rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i
);

  import xbar_pkg::*;

  typedef enum logic {
    ERR_IDLE,
    ERR_RESP
  } err_state_e;

  err_state_e state_q;
  init_id_t   id_q;

  assign req_ready_o = (state_q == ERR_IDLE);
  assign rsp_valid_o = (state_q == ERR_RESP);

  // Only the ID comes back, data is always zero
  assign rsp_o = '{rdata: '0, resp: DECERR, id: id_q};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ERR_IDLE;
    end else begin
      case (state_q)
        ERR_IDLE: if (req_valid_i) state_q <= ERR_RESP;
        ERR_RESP: if (rsp_ready_i) state_q <= ERR_IDLE;
        default:  state_q <= ERR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      id_q <= req_i.id;
    end
  end

endmodule

`default_nettype wire

// ==== source/xbar_demux.sv ====
// Initiator side request router
`timescale 1ns/1ps
`default_nettype none

module xbar_demux (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  xbar_pkg::init_req_t                         init_req_i,
  input  logic                                        init_req_valid_i,
  output logic                                        init_req_ready_o,
  output xbar_pkg::init_rsp_t                         init_rsp_o,
  output logic                                        init_rsp_valid_o,
  input  logic                                        init_rsp_ready_i,
  output xbar_pkg::init_req_t [xbar_pkg::NUM_TGT-1:0] tgt_req_o,
  output logic [xbar_pkg::NUM_TGT-1:0]                tgt_req_valid_o,
  input  logic [xbar_pkg::NUM_TGT-1:0]                tgt_req_ready_i,
  input  xbar_pkg::init_rsp_t [xbar_pkg::NUM_TGT-1:0] tgt_rsp_i,
  input  logic [xbar_pkg::NUM_TGT-1:0]                tgt_rsp_valid_i,
  output logic [xbar_pkg::NUM_TGT-1:0]                tgt_rsp_ready_o
);

  import xbar_pkg::*;

  localparam int unsigned CNT_W     = $clog2(MAX_TRANS + 1);
  localparam route_t      ERR_ROUTE = route_t'(NUM_TGT);

  typedef logic [CNT_W-1:0] cnt_t;

  route_t    dec_route;
  route_t    route_q;       // Route of the requests in flight
  cnt_t      cnt_q;
  logic      busy;
  logic      stall;
  logic      req_fire;
  logic      rsp_fire;
  logic      err_req_valid;
  logic      err_req_ready;
  init_rsp_t err_rsp;
  logic      err_rsp_valid;
  logic      err_rsp_ready;

  xbar_addr_decode xbar_addr_decode_inst (
    .addr_i  (init_req_i.addr),
    .route_o (dec_route)
  );

  xbar_err_resp xbar_err_resp_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (init_req_i),
    .req_valid_i (err_req_valid),
    .req_ready_o (err_req_ready),
    .rsp_o       (err_rsp),
    .rsp_valid_o (err_rsp_valid),
    .rsp_ready_i (err_rsp_ready)
  );

  assign busy = (cnt_q != '0);

  // Full, or a switch of route would reorder responses
  assign stall = (cnt_q == cnt_t'(MAX_TRANS)) || (busy && (route_q != dec_route));

  always_comb begin
    init_req_ready_o = 1'b0;
    for (int j = 0; j < NUM_TGT; j++) begin
      tgt_req_o[j]       = init_req_i;
      tgt_req_valid_o[j] = init_req_valid_i && !stall && (dec_route == route_t'(j));
      if (dec_route == route_t'(j)) begin
        init_req_ready_o = tgt_req_ready_i[j] && !stall;
      end
    end
    err_req_valid = init_req_valid_i && !stall && (dec_route == ERR_ROUTE);
    if (dec_route == ERR_ROUTE) begin
      init_req_ready_o = err_req_ready && !stall;
    end
  end

  // Responses only come from the locked route
  always_comb begin
    init_rsp_o       = err_rsp;
    init_rsp_valid_o = busy && err_rsp_valid && (route_q == ERR_ROUTE);
    err_rsp_ready    = busy && init_rsp_ready_i && (route_q == ERR_ROUTE);
    for (int j = 0; j < NUM_TGT; j++) begin
      tgt_rsp_ready_o[j] = busy && init_rsp_ready_i && (route_q == route_t'(j));
      if (route_q == route_t'(j)) begin
        init_rsp_o       = tgt_rsp_i[j];
        init_rsp_valid_o = busy && tgt_rsp_valid_i[j];
      end
    end
  end

  assign req_fire = init_req_valid_i && init_req_ready_o;
  assign rsp_fire = init_rsp_valid_o && init_rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= '0;
      route_q <= '0;
    end else begin
      if (req_fire) route_q <= dec_route;
      case ({req_fire, rsp_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // None or both
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/xbar_mux.sv ====
// Target side arbiter with ID extension
`timescale 1ns/1ps
`default_nettype none

module xbar_mux (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  xbar_pkg::init_req_t [xbar_pkg::NUM_INIT-1:0] init_req_i,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_req_valid_i,
  output logic [xbar_pkg::NUM_INIT-1:0]                init_req_ready_o,
  output xbar_pkg::init_rsp_t [xbar_pkg::NUM_INIT-1:0] init_rsp_o,
  output logic [xbar_pkg::NUM_INIT-1:0]                init_rsp_valid_o,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_rsp_ready_i,
  output xbar_pkg::tgt_req_t                           tgt_req_o,
  output logic                                         tgt_req_valid_o,
  input  logic                                         tgt_req_ready_i,
  input  xbar_pkg::tgt_rsp_t                           tgt_rsp_i,
  input  logic                                         tgt_rsp_valid_i,
  output logic                                         tgt_rsp_ready_o
);

  import xbar_pkg::*;

  typedef logic [INIT_IDX_W-1:0] init_idx_t;

  init_idx_t rr_q;     // Initiator with the highest priority
  init_idx_t sel_q;
  logic      lock_q;
  init_idx_t sel;
  init_idx_t rsp_dst;
  logic      req_fire;

  // Round robin search starting at the pointer
  always_comb begin : grant
    logic      found;
    init_idx_t cand;
    found = 1'b0;
    sel   = rr_q;
    for (int k = 0; k < NUM_INIT; k++) begin
      cand = rr_q + init_idx_t'(k);
      if (!found && init_req_valid_i[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
    if (lock_q) sel = sel_q;  // Pending request keeps its grant
  end

  assign tgt_req_valid_o = init_req_valid_i[sel];
  assign tgt_req_o = '{
    addr:  init_req_i[sel].addr,
    we:    init_req_i[sel].we,
    wdata: init_req_i[sel].wdata,
    id:    {sel, init_req_i[sel].id}
  };

  always_comb begin
    for (int i = 0; i < NUM_INIT; i++) begin
      init_req_ready_o[i] = tgt_req_ready_i && (sel == init_idx_t'(i));
    end
  end

  assign req_fire = tgt_req_valid_o && tgt_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q   <= '0;
      sel_q  <= '0;
      lock_q <= 1'b0;
    end else if (req_fire) begin
      lock_q <= 1'b0;
      rr_q   <= sel + 1'b1;  // Winner drops to lowest priority
    end else if (tgt_req_valid_o) begin
      lock_q <= 1'b1;
      sel_q  <= sel;
    end
  end

  // Top ID bits name the initiator that owns the response
  assign rsp_dst         = tgt_rsp_i.id[TGT_ID_W-1 -: INIT_IDX_W];
  assign tgt_rsp_ready_o = init_rsp_ready_i[rsp_dst];

  always_comb begin
    for (int i = 0; i < NUM_INIT; i++) begin
      init_rsp_o[i] = '{
        rdata: tgt_rsp_i.rdata,
        resp:  tgt_rsp_i.resp,
        id:    tgt_rsp_i.id[INIT_ID_W-1:0]
      };
      init_rsp_valid_o[i] = tgt_rsp_valid_i && (rsp_dst == init_idx_t'(i));
    end
  end

endmodule

`default_nettype wire

// ==== source/xbar_top.sv ====
// Two by two crossbar
`timescale 1ns/1ps
`default_nettype none

module xbar_top (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  xbar_pkg::init_req_t [xbar_pkg::NUM_INIT-1:0] init_req_i,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_req_valid_i,
  output logic [xbar_pkg::NUM_INIT-1:0]                init_req_ready_o,
  output xbar_pkg::init_rsp_t [xbar_pkg::NUM_INIT-1:0] init_rsp_o,
  output logic [xbar_pkg::NUM_INIT-1:0]                init_rsp_valid_o,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_rsp_ready_i,
  output xbar_pkg::tgt_req_t [xbar_pkg::NUM_TGT-1:0]   tgt_req_o,
  output logic [xbar_pkg::NUM_TGT-1:0]                 tgt_req_valid_o,
  input  logic [xbar_pkg::NUM_TGT-1:0]                 tgt_req_ready_i,
  input  xbar_pkg::tgt_rsp_t [xbar_pkg::NUM_TGT-1:0]   tgt_rsp_i,
  input  logic [xbar_pkg::NUM_TGT-1:0]                 tgt_rsp_valid_i,
  output logic [xbar_pkg::NUM_TGT-1:0]                 tgt_rsp_ready_o
);

  import xbar_pkg::*;

  // Demux side, indexed [initiator][target]
  init_req_t [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req;
  logic      [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req_valid;
  logic      [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req_ready;
  init_rsp_t [NUM_INIT-1:0][NUM_TGT-1:0] dmx_rsp;
  logic      [NUM_INIT-1:0][NUM_TGT-1:0] dmx_rsp_valid;
  logic      [NUM_INIT-1:0][NUM_TGT-1:0] dmx_rsp_ready;

  // Mux side, indexed [target][initiator]
  init_req_t [NUM_TGT-1:0][NUM_INIT-1:0] mux_req;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_valid;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_ready;
  init_rsp_t [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp_valid;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp_ready;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_demux
    xbar_demux xbar_demux_inst (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .init_req_i       (init_req_i[i]),
      .init_req_valid_i (init_req_valid_i[i]),
      .init_req_ready_o (init_req_ready_o[i]),
      .init_rsp_o       (init_rsp_o[i]),
      .init_rsp_valid_o (init_rsp_valid_o[i]),
      .init_rsp_ready_i (init_rsp_ready_i[i]),
      .tgt_req_o        (dmx_req[i]),
      .tgt_req_valid_o  (dmx_req_valid[i]),
      .tgt_req_ready_i  (dmx_req_ready[i]),
      .tgt_rsp_i        (dmx_rsp[i]),
      .tgt_rsp_valid_i  (dmx_rsp_valid[i]),
      .tgt_rsp_ready_o  (dmx_rsp_ready[i])
    );
  end

  // Every initiator reaches every target
  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross_init
    for (genvar j = 0; j < NUM_TGT; j++) begin : gen_cross_tgt
      assign mux_req[j][i]       = dmx_req[i][j];
      assign mux_req_valid[j][i] = dmx_req_valid[i][j];
      assign dmx_req_ready[i][j] = mux_req_ready[j][i];
      assign dmx_rsp[i][j]       = mux_rsp[j][i];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_mux
    xbar_mux xbar_mux_inst (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .init_req_i       (mux_req[j]),
      .init_req_valid_i (mux_req_valid[j]),
      .init_req_ready_o (mux_req_ready[j]),
      .init_rsp_o       (mux_rsp[j]),
      .init_rsp_valid_o (mux_rsp_valid[j]),
      .init_rsp_ready_i (mux_rsp_ready[j]),
      .tgt_req_o        (tgt_req_o[j]),
      .tgt_req_valid_o  (tgt_req_valid_o[j]),
      .tgt_req_ready_i  (tgt_req_ready_i[j]),
      .tgt_rsp_i        (tgt_rsp_i[j]),
      .tgt_rsp_valid_i  (tgt_rsp_valid_i[j]),
      .tgt_rsp_ready_o  (tgt_rsp_ready_o[j])
    );
  end

endmodule

`default_nettype wire

// ==== tb/xbar_checker.sv ====
// Crossbar response checker
`timescale 1ns/1ps
`default_nettype none

module xbar_checker (
  input  logic                                         clk_i,
  input  logic [8*12-1:0]                              test_name_i,
  input  logic                                         test_done_i,
  input  xbar_pkg::init_req_t [xbar_pkg::NUM_INIT-1:0] init_req_i,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_req_valid_i,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_req_ready_i,
  input  xbar_pkg::init_rsp_t [xbar_pkg::NUM_INIT-1:0] init_rsp_i,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_rsp_valid_i,
  input  logic [xbar_pkg::NUM_INIT-1:0]                init_rsp_ready_i,
  input  xbar_pkg::tgt_req_t [xbar_pkg::NUM_TGT-1:0]   tgt_req_i,
  input  logic [xbar_pkg::NUM_TGT-1:0]                 tgt_req_valid_i,
  input  logic [xbar_pkg::NUM_TGT-1:0]                 tgt_req_ready_i,
  output int                                           error_count_o,
  output int                                           fail_count_o
);

  import xbar_pkg::*;

  data_t     mem [NUM_TGT][16];        // Own copy of the target memories
  init_rsp_t exp_buf [NUM_INIT][16];   // Expected responses in issue order
  int        wr_ptr [NUM_INIT];
  int        rd_ptr [NUM_INIT];
  int        test_errors;

  // Address map with 2 for unmapped
  function automatic int route_of(input addr_t addr);
    if (addr >= TGT0_BASE && addr <= TGT0_END) return 0;
    if (addr >= TGT1_BASE && addr <= TGT1_END) return 1;
    return 2;
  endfunction

  task automatic count_error();
    error_count_o++;
    test_errors++;
  endtask

  initial begin
    error_count_o = 0;
    fail_count_o  = 0;
    test_errors   = 0;
    for (int i = 0; i < NUM_INIT; i++) begin
      wr_ptr[i] = 0;
      rd_ptr[i] = 0;
    end
    for (int t = 0; t < NUM_TGT; t++) begin
      for (int k = 0; k < 16; k++) mem[t][k] = data_t'(k);
    end
  end

  // Handshakes seen here complete on the next rising edge
  always @(negedge clk_i) begin : watch
    init_rsp_t want;
    tgt_req_t  fwd;
    int        rt;
    int        src;
    for (int i = 0; i < NUM_INIT; i++) begin
      if (init_req_valid_i[i] && init_req_ready_i[i]) begin
        rt         = route_of(init_req_i[i].addr);
        want.rdata = '0;
        want.resp  = OKAY;
        want.id    = init_req_i[i].id;
        if (rt == 2) begin
          want.resp = DECERR;
        end else if (init_req_i[i].we) begin
          mem[rt][init_req_i[i].addr[3:0]] = init_req_i[i].wdata;
        end else begin
          want.rdata = mem[rt][init_req_i[i].addr[3:0]];
        end
        exp_buf[i][wr_ptr[i]] = want;
        wr_ptr[i] = (wr_ptr[i] + 1) % 16;
        if (rt != 2) begin
          fwd = '{addr: init_req_i[i].addr, we: init_req_i[i].we,
                  wdata: init_req_i[i].wdata, id: {i[0], init_req_i[i].id}};
          if (!(tgt_req_valid_i[rt] && tgt_req_ready_i[rt])) begin
            $display("%0s: request from initiator %0d never reached target %0d",
                     test_name_i, i, rt);
            count_error();
          end else if (tgt_req_i[rt] !== fwd) begin
            $display("error %0s: target %0d request expected %h actual %h",
                     test_name_i, rt, fwd, tgt_req_i[rt]);
            count_error();
          end
        end
      end
    end
    for (int j = 0; j < NUM_TGT; j++) begin
      if (tgt_req_valid_i[j] && tgt_req_ready_i[j]) begin
        src = tgt_req_i[j].id[TGT_ID_W-1];   // Initiator index in the top ID bit
        if (!(init_req_valid_i[src] && init_req_ready_i[src]) ||
            route_of(init_req_i[src].addr) != j) begin
          $display("%0s: target %0d took a request that no initiator sent to it",
                   test_name_i, j);
          count_error();
        end
      end
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      if (init_rsp_valid_i[i] && init_rsp_ready_i[i]) begin
        if (rd_ptr[i] == wr_ptr[i]) begin
          $display("%0s: initiator %0d got a response with nothing outstanding",
                   test_name_i, i);
          count_error();
        end else begin
          if (init_rsp_i[i] !== exp_buf[i][rd_ptr[i]]) begin
            $display("error %0s: initiator %0d response expected %h actual %h",
                     test_name_i, i, exp_buf[i][rd_ptr[i]], init_rsp_i[i]);
            count_error();
          end
          rd_ptr[i] = (rd_ptr[i] + 1) % 16;
        end
      end
    end
    if (test_done_i) begin
      for (int i = 0; i < NUM_INIT; i++) begin
        if (rd_ptr[i] != wr_ptr[i]) begin
          $display("%0s: initiator %0d is still missing responses", test_name_i, i);
          count_error();
        end
      end
      if (test_errors == 0) begin
        $display("test %0s passed", test_name_i);
      end else begin
        $display("test %0s failed with %0d errors", test_name_i, test_errors);
        fail_count_o++;
      end
      test_errors = 0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_xbar.sv ====
// Crossbar testbench
`timescale 1ns/1ps
`default_nettype none

module tb_xbar;

  import xbar_pkg::*;

  localparam int NUM_ROWS = 5;
  localparam int MAX_REQ  = 8;

  logic                     clk;
  logic                     rst_n;
  init_req_t [NUM_INIT-1:0] init_req;
  logic [NUM_INIT-1:0]      init_req_valid;
  logic [NUM_INIT-1:0]      init_req_ready;
  init_rsp_t [NUM_INIT-1:0] init_rsp;
  logic [NUM_INIT-1:0]      init_rsp_valid;
  logic [NUM_INIT-1:0]      init_rsp_ready;
  tgt_req_t [NUM_TGT-1:0]   tgt_req;
  logic [NUM_TGT-1:0]       tgt_req_valid;
  logic [NUM_TGT-1:0]       tgt_req_ready;
  tgt_rsp_t [NUM_TGT-1:0]   tgt_rsp;
  logic [NUM_TGT-1:0]       tgt_rsp_valid;
  logic [NUM_TGT-1:0]       tgt_rsp_ready;

  // Stimulus table, one row per test
  logic [8*12-1:0] row_name [NUM_ROWS];
  logic            row_bp   [NUM_ROWS];      // Random target back-pressure
  int              row_cnt  [NUM_ROWS][NUM_INIT];
  init_req_t       row_req  [NUM_ROWS][NUM_INIT][MAX_REQ];

  data_t           mem [NUM_TGT][16];         // Target memory models
  logic [8*12-1:0] cur_name;
  logic            bp_on;
  logic            test_done;
  int              rsp_cnt [NUM_INIT];
  int              exp_cnt [NUM_INIT];
  int              cycles;
  int              cycle_limit;
  int              error_count;
  int              fail_count;
  integer          seed;

  xbar_top xbar_top_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .init_req_i       (init_req),
    .init_req_valid_i (init_req_valid),
    .init_req_ready_o (init_req_ready),
    .init_rsp_o       (init_rsp),
    .init_rsp_valid_o (init_rsp_valid),
    .init_rsp_ready_i (init_rsp_ready),
    .tgt_req_o        (tgt_req),
    .tgt_req_valid_o  (tgt_req_valid),
    .tgt_req_ready_i  (tgt_req_ready),
    .tgt_rsp_i        (tgt_rsp),
    .tgt_rsp_valid_i  (tgt_rsp_valid),
    .tgt_rsp_ready_o  (tgt_rsp_ready)
  );

  xbar_checker xbar_checker_inst (
    .clk_i            (clk),
    .test_name_i      (cur_name),
    .test_done_i      (test_done),
    .init_req_i       (init_req),
    .init_req_valid_i (init_req_valid),
    .init_req_ready_i (init_req_ready),
    .init_rsp_i       (init_rsp),
    .init_rsp_valid_i (init_rsp_valid),
    .init_rsp_ready_i (init_rsp_ready),
    .tgt_req_i        (tgt_req),
    .tgt_req_valid_i  (tgt_req_valid),
    .tgt_req_ready_i  (tgt_req_ready),
    .error_count_o    (error_count),
    .fail_count_o     (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic add_req(input int r, input int i, input addr_t addr, input logic we,
                         input data_t wdata);
    init_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.wdata = wdata;
    req.id    = init_id_t'(row_cnt[r][i]);  // IDs cycle through all values
    row_req[r][i][row_cnt[r][i]] = req;
    row_cnt[r][i]++;
  endtask

  task automatic build_table();
    int total;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_bp[r] = 1'b0;
      for (int i = 0; i < NUM_INIT; i++) row_cnt[r][i] = 0;
    end
    row_name[0] = "write_read";
    add_req(0, 0, 16'h0001, 1'b1, 32'hA000_0001);
    add_req(0, 0, 16'h1002, 1'b1, 32'hA000_1002);
    add_req(0, 0, 16'h0001, 1'b0, '0);
    add_req(0, 0, 16'h1002, 1'b0, '0);
    add_req(0, 0, 16'h0003, 1'b0, '0);           // Never written
    add_req(0, 1, 16'h0005, 1'b1, 32'hB000_0005);
    add_req(0, 1, 16'h0005, 1'b0, '0);
    add_req(0, 1, 16'h1006, 1'b1, 32'hB000_1006);
    add_req(0, 1, 16'h1006, 1'b0, '0);
    add_req(0, 1, 16'h1007, 1'b0, '0);
    row_name[1] = "decode_err";
    add_req(1, 0, 16'h2000, 1'b0, '0);
    add_req(1, 0, 16'h8004, 1'b1, 32'hDEAD_0004);
    add_req(1, 1, 16'hFFFF, 1'b0, '0);
    add_req(1, 1, 16'h3000, 1'b1, 32'hDEAD_3000);
    row_name[2] = "same_target";                // Both hit target 0
    add_req(2, 0, 16'h0008, 1'b1, 32'hC000_0008);
    add_req(2, 0, 16'h0008, 1'b0, '0);
    add_req(2, 0, 16'h0009, 1'b0, '0);
    add_req(2, 1, 16'h000A, 1'b1, 32'hC100_000A);
    add_req(2, 1, 16'h000A, 1'b0, '0);
    add_req(2, 1, 16'h000B, 1'b0, '0);
    row_name[3] = "backpressure";
    row_bp[3]   = 1'b1;
    add_req(3, 0, 16'h100C, 1'b1, 32'hD000_100C);
    add_req(3, 0, 16'h100C, 1'b0, '0);
    add_req(3, 0, 16'h0004, 1'b0, '0);
    add_req(3, 0, 16'h000D, 1'b0, '0);
    add_req(3, 1, 16'h000E, 1'b1, 32'hD100_000E);
    add_req(3, 1, 16'h000E, 1'b0, '0);
    add_req(3, 1, 16'h1001, 1'b0, '0);
    row_name[4] = "mixed_order";
    add_req(4, 0, 16'h0002, 1'b0, '0);
    add_req(4, 0, 16'h1003, 1'b0, '0);
    add_req(4, 0, 16'h4000, 1'b0, '0);
    add_req(4, 0, 16'h0006, 1'b1, 32'hE000_0006);
    add_req(4, 0, 16'h1004, 1'b0, '0);
    add_req(4, 0, 16'h9000, 1'b1, 32'hE000_9000);
    add_req(4, 0, 16'h0006, 1'b0, '0);
    add_req(4, 1, 16'h100F, 1'b0, '0);
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < NUM_INIT; i++) total += row_cnt[r][i];
    end
    cycle_limit = 40 * total + 100;
    for (int t = 0; t < NUM_TGT; t++) begin
      for (int k = 0; k < 16; k++) mem[t][k] = data_t'(k);  // Preload word index
    end
  endtask

  // One initiator issues its row requests back to back
  task automatic drive_init(input int r, input int i);
    for (int k = 0; k < row_cnt[r][i]; k++) begin
      init_req[i]       = row_req[r][i][k];
      init_req_valid[i] = 1'b1;
      @(negedge clk);
      while (!init_req_ready[i]) @(negedge clk);
      @(posedge clk);
      #1;
    end
    init_req_valid[i] = 1'b0;
  endtask

  // Targets hold one request at a time and answer a cycle after acceptance
  always begin : tgt_models
    logic [NUM_TGT-1:0] acc;
    logic [NUM_TGT-1:0] ret;
    tgt_req_t           hold [NUM_TGT];
    @(negedge clk);
    for (int t = 0; t < NUM_TGT; t++) begin
      acc[t]  = tgt_req_valid[t] && tgt_req_ready[t];
      ret[t]  = tgt_rsp_valid[t] && tgt_rsp_ready[t];
      hold[t] = tgt_req[t];
    end
    @(posedge clk);
    #1;
    for (int t = 0; t < NUM_TGT; t++) begin
      if (ret[t]) tgt_rsp_valid[t] = 1'b0;
      if (acc[t]) begin
        tgt_rsp[t].rdata = hold[t].we ? data_t'(0) : mem[t][hold[t].addr[3:0]];
        tgt_rsp[t].resp  = OKAY;
        tgt_rsp[t].id    = hold[t].id;                  // Echo extended ID
        if (hold[t].we) mem[t][hold[t].addr[3:0]] = hold[t].wdata;
        tgt_rsp_valid[t] = 1'b1;
      end
      tgt_req_ready[t] = !tgt_rsp_valid[t] && (!bp_on || ({$random(seed)} % 3 != 0));
    end
  end

  always @(negedge clk) begin
    for (int i = 0; i < NUM_INIT; i++) begin
      if (init_rsp_valid[i] && init_rsp_ready[i]) rsp_cnt[i] <= rsp_cnt[i] + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin : run
    rst_n          = 1'b0;
    init_req       = '0;
    init_req_valid = '0;
    init_rsp_ready = '1;   // Initiators always take responses
    tgt_req_ready  = '0;
    tgt_rsp        = '0;
    tgt_rsp_valid  = '0;
    test_done      = 1'b0;
    bp_on          = 1'b0;
    cur_name       = '0;
    seed           = 54582;
    cycles         = 0;
    for (int i = 0; i < NUM_INIT; i++) begin
      rsp_cnt[i] = 0;
      exp_cnt[i] = 0;
    end
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name = row_name[r];
      bp_on    = row_bp[r];
      for (int i = 0; i < NUM_INIT; i++) exp_cnt[i] += row_cnt[r][i];
      fork
        drive_init(r, 0);
        drive_init(r, 1);
      join
      while (rsp_cnt[0] < exp_cnt[0] || rsp_cnt[1] < exp_cnt[1]) @(posedge clk);
      #1;
      test_done = 1'b1;
      @(posedge clk);
      #1;
      test_done = 1'b0;
    end
    $display("%0d tests, %0d failed, %0d errors", NUM_ROWS, fail_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/xbar_pkg.sv
source/xbar_addr_decode.sv
source/xbar_err_resp.sv
source/xbar_demux.sv
source/xbar_mux.sv
source/xbar_top.sv
tb/xbar_checker.sv
tb/tb_xbar.sv
